// File: src/zx_mem_pkg.sv
`default_nettype none

package zx_mem_pkg;

	// ======================================================================
	// Flat memory map of the shared word memory
	// ======================================================================

	localparam int BYTE_ADDR_W   = 25;  // Byte address width
	localparam int WORD_BITS_DEF = 21;  // Word address bits actually stored

	// Region bases, all byte addresses
	localparam logic [BYTE_ADDR_W-1:0] RAM_BASE = 25'h000000; // Banks 0..7, 16 KB each
	localparam logic [BYTE_ADDR_W-1:0] ROM_BASE = 25'h140000; // 16 ROM slots of 16 KB
	localparam logic [BYTE_ADDR_W-1:0] GS_BASE  = 25'h200000; // General Sound region
	localparam logic [BYTE_ADDR_W-1:0] DL_BASE  = 25'h000000; // Download offset

	// One byte address, seen whole or as word plus byte lane
	typedef union packed {
		logic [BYTE_ADDR_W-1:0] byte_addr;
		struct packed {
			logic [BYTE_ADDR_W-2:0] word;
			logic                   lane;  // 1 selects the upper byte
		} w;
	} mem_addr_u;

endpackage

`default_nettype wire

// File: src/zx_io_pkg.sv
`default_nettype none

package zx_io_pkg;

	// Machine models
	localparam logic [1:0] MODEL_128 = 2'd0;
	localparam logic [1:0] MODEL_48  = 2'd1;
	localparam logic [1:0] MODEL_P3  = 2'd2;

	// GS memory size select
	localparam logic [1:0] GS_SIZE_512K  = 2'd0;
	localparam logic [1:0] GS_SIZE_1M    = 2'd1;
	localparam logic [1:0] GS_SIZE_2M    = 2'd2;
	localparam logic [1:0] GS_SIZE_2M_UP = 2'd3;  // Same as 2M

	// 7FFD, partial decode; the +3 also needs A14 high
	function automatic logic port_7ffd_hit(input logic [15:0] a, input logic plus3);
		return ~a[15] & ~a[1] & (a[14] | ~plus3);
	endfunction

	// 1FFD exists on the +3 only
	function automatic logic port_1ffd_hit(input logic [15:0] a, input logic plus3);
		return plus3 & a[12] & ~a[15] & ~a[14] & ~a[13] & ~a[1];
	endfunction

endpackage

`default_nettype wire

// File: src/zx_paging.sv
`default_nettype none
`timescale 1ns/1ns

module zx_paging (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire  [15:0]           cpu_addr,
	input  wire  [7:0]            cpu_dout,
	input  wire                   cpu_mreq,
	input  wire                   cpu_iorq,
	input  wire                   cpu_rd,
	input  wire                   cpu_wr,
	input  wire  [1:0]            model,
	output zx_mem_pkg::mem_addr_u ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we,
	output logic [7:0]            ram_din
);
	import zx_mem_pkg::*;
	import zx_io_pkg::*;

	logic [1:0]      model_q;         // Model sampled during reset
	logic [7:0]      page_reg;        // 7FFD
	logic [7:0]      page_reg_plus3;  // 1FFD
	logic            io_wr_d;
	logic            io_wr;
	logic            io_wr_rise;
	logic            is48;
	logic            plus3;
	logic            page_lock;
	logic            page_special;
	logic [3:0]      rom_slot;
	logic [3:0][2:0] special_set;
	logic [2:0]      bank;

	assign is48         = (model_q == MODEL_48);
	assign plus3        = (model_q == MODEL_P3);
	assign page_lock    = is48 | page_reg[5];  // 48K never pages
	assign page_special = page_reg_plus3[0];   // +3 all-RAM mode

	// ======================================================================
	// Page registers
	// ======================================================================

	assign io_wr      = cpu_iorq & cpu_wr;
	assign io_wr_rise = io_wr & ~io_wr_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d        <= 1'b0;
			model_q        <= (model == 2'd3) ? MODEL_128 : model;
			page_reg       <= 8'h00;
			page_reg_plus3 <= 8'h00;
		end else begin
			io_wr_d <= io_wr;
			if (io_wr_rise & ~page_lock) begin
				if (port_7ffd_hit(cpu_addr, plus3))
					page_reg <= cpu_dout;
				else if (port_1ffd_hit(cpu_addr, plus3))
					page_reg_plus3 <= cpu_dout;
			end
		end
	end

	// ======================================================================
	// CPU address to flat byte address
	// ======================================================================

	always_comb begin
		case (model_q)
			MODEL_48: rom_slot = 4'd15;
			MODEL_P3: rom_slot = {2'b10, page_reg_plus3[2], page_reg[4]};
			default:  rom_slot = {3'b011, page_reg[4]};  // 128K ROM 0 or 1
		endcase
	end

	// Special mode bank sets, slot 0 in the low element
	always_comb begin
		case (page_reg_plus3[2:1])
			2'd0:    special_set = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    special_set = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    special_set = {3'd3, 3'd6, 3'd5, 3'd4};
			default: special_set = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
	end

	always_comb begin
		bank = special_set[cpu_addr[15:14]];
		if (!page_special) begin
			case (cpu_addr[15:14])
				2'd1:    bank = 3'd5;
				2'd2:    bank = 3'd2;
				default: bank = page_reg[2:0];  // Slot 0 goes to ROM below
			endcase
		end
		if (!page_special && cpu_addr[15:14] == 2'd0)
			ram_addr.byte_addr = ROM_BASE + {7'd0, rom_slot, cpu_addr[13:0]};
		else
			ram_addr.byte_addr = RAM_BASE + {8'd0, bank, cpu_addr[13:0]};
	end

	assign ram_rd  = cpu_mreq & cpu_rd;
	// ROM area is read only outside special mode
	assign ram_we  = cpu_mreq & cpu_wr & (page_special | cpu_addr[15] | cpu_addr[14]);
	assign ram_din = cpu_dout;

endmodule

`default_nettype wire

// File: src/cpu_mem_port.sv
`default_nettype none
`timescale 1ns/1ns

module cpu_mem_port (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire zx_mem_pkg::mem_addr_u ram_addr,
	input  wire                        ram_rd,
	input  wire                        ram_we,
	input  wire  [7:0]                 ram_din,
	input  wire                        dl_active,
	input  wire                        dl_wr,
	input  wire  [24:0]                dl_addr,
	input  wire  [7:0]                 dl_data,
	input  wire                        ack,
	input  wire  [15:0]                q,
	output logic                       req,
	output zx_mem_pkg::mem_addr_u      addr,
	output logic                       we,
	output logic [15:0]                din,
	output logic [1:0]                 ds,
	output logic [7:0]                 ram_dout,
	output logic                       ram_ready
);
	import zx_mem_pkg::*;

	mem_addr_u  src_addr;
	logic       src_rd;
	logic       src_we;
	logic [7:0] src_data;
	logic       rd_d1;
	logic       rd_d2;  // Extra delay lets the paged address settle
	logic       we_d;
	logic       new_req;

	// Download takes the port over and the CPU bus is ignored
	always_comb begin
		if (dl_active) begin
			src_addr.byte_addr = DL_BASE + dl_addr;
			src_rd             = 1'b0;
			src_we             = dl_wr;
			src_data           = dl_data;
		end else begin
			src_addr = ram_addr;
			src_rd   = ram_rd;
			src_we   = ram_we;
			src_data = ram_din;
		end
	end

	assign new_req = (rd_d1 & ~rd_d2) | (src_we & ~we_d);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_d1 <= 1'b0;
			rd_d2 <= 1'b0;
			we_d  <= 1'b0;
			req   <= 1'b0;
		end else begin
			rd_d1 <= src_rd;
			rd_d2 <= rd_d1;
			we_d  <= src_we;
			if (new_req)
				req <= ~req;  // Toggle starts the access
		end
	end

	// Request payload, held until the next request
	always_ff @(posedge clk_sys) begin
		if (new_req) begin
			addr <= src_addr;
			we   <= src_we;
			din  <= {src_data, src_data};
			ds   <= src_we ? {src_addr.w.lane, ~src_addr.w.lane} : 2'b11;
		end
	end

	assign ram_dout  = addr.w.lane ? q[15:8] : q[7:0];
	assign ram_ready = (ack == req) & ~new_req;

endmodule

`default_nettype wire

// File: src/gs_mem_port.sv
`default_nettype none
`timescale 1ns/1ns

module gs_mem_port (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire  [20:0]           gs_addr,
	input  wire  [7:0]            gs_din,
	input  wire                   gs_rd,
	input  wire                   gs_wr,
	input  wire  [1:0]            gs_size,
	input  wire                   ack,
	input  wire  [15:0]           q,
	output logic                  req,
	output zx_mem_pkg::mem_addr_u addr,
	output logic                  we,
	output logic [15:0]           din,
	output logic [1:0]            ds,
	output logic [7:0]            gs_dout,
	output logic                  gs_ready
);
	import zx_mem_pkg::*;
	import zx_io_pkg::*;

	mem_addr_u  next_addr;
	logic       rd_d;
	logic       wr_d;
	logic       new_req;
	logic       issue;
	logic       rd_valid;  // q holds the word at addr
	logic       lane_sel;
	logic [7:0] mask;

	assign next_addr.byte_addr = GS_BASE + {4'd0, gs_addr};

	assign new_req = (gs_rd & ~rd_d) | (gs_wr & ~wr_d);

	// A read of the held word needs no memory access
	assign issue = gs_wr | ~rd_valid | (next_addr.w.word != addr.w.word);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_d     <= 1'b0;
			wr_d     <= 1'b0;
			req      <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_d <= gs_rd;
			wr_d <= gs_wr;
			if (new_req & issue) begin
				req      <= ~req;
				rd_valid <= ~gs_wr;  // A write spoils the held word
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (new_req) begin
			addr <= next_addr;  // Lane moves even on reuse
			if (issue) begin
				we  <= gs_wr;
				din <= {gs_din, gs_din};
				ds  <= gs_wr ? {next_addr.w.lane, ~next_addr.w.lane} : 2'b11;
			end
		end
	end

	// ======================================================================
	// Read data and size mask
	// ======================================================================

	// New lane is needed at once when a reused read keeps ready high
	assign lane_sel = new_req ? next_addr.w.lane : addr.w.lane;

	always_comb begin
		case (gs_size)
			GS_SIZE_512K:              mask = (gs_addr[20:19] != 2'b00) ? 8'hFF : 8'h00;
			GS_SIZE_1M:                mask = gs_addr[20] ? 8'hFF : 8'h00;
			GS_SIZE_2M, GS_SIZE_2M_UP: mask = 8'h00;
		endcase
	end

	assign gs_dout  = (lane_sel ? q[15:8] : q[7:0]) | mask;
	assign gs_ready = (ack == req) & ~(new_req & issue);

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module mem_arbiter (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        a_req,
	input  wire zx_mem_pkg::mem_addr_u a_addr,
	input  wire                        a_we,
	input  wire  [15:0]                a_din,
	input  wire  [1:0]                 a_ds,
	output logic                       a_ack,
	output logic [15:0]                a_q,
	input  wire                        b_req,
	input  wire zx_mem_pkg::mem_addr_u b_addr,
	input  wire                        b_we,
	input  wire  [15:0]                b_din,
	input  wire  [1:0]                 b_ds,
	output logic                       b_ack,
	output logic [15:0]                b_q,
	input  wire  [15:0]                mem_q,
	output logic                       mem_en,
	output logic                       mem_we,
	output logic [23:0]                mem_addr,
	output logic [15:0]                mem_d,
	output logic [1:0]                 mem_ds
);

	localparam logic       ST_IDLE  = 1'b0;
	localparam logic       ST_BUSY  = 1'b1;
	localparam logic [1:0] READ_LAT = 2'd2;  // Word memory read latency

	logic       state;
	logic       grant_b;  // Port b is being served
	logic [1:0] lat_cnt;
	logic       a_pend;
	logic       b_pend;
	logic       done;

	assign a_pend = (a_req != a_ack);
	assign b_pend = (b_req != b_ack);
	assign done   = (state == ST_BUSY) && (lat_cnt == READ_LAT);

	// ======================================================================
	// Grant FSM, port a (CPU) first
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= ST_IDLE;
			grant_b <= 1'b0;
			lat_cnt <= 2'd0;
			mem_en  <= 1'b0;
			a_ack   <= 1'b0;
			b_ack   <= 1'b0;
		end else begin
			mem_en <= 1'b0;  // One-cycle strobe
			case (state)
				ST_IDLE: begin
					if (a_pend | b_pend) begin
						grant_b <= ~a_pend;
						lat_cnt <= 2'd0;
						mem_en  <= 1'b1;
						state   <= ST_BUSY;
					end
				end
				default: begin
					lat_cnt <= lat_cnt + 2'd1;
					if (done) begin
						state <= ST_IDLE;
						if (grant_b)
							b_ack <= b_req;
						else
							a_ack <= a_req;
					end
				end
			endcase
		end
	end

	// Memory command and per-port read words
	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && (a_pend | b_pend)) begin
			mem_we   <= a_pend ? a_we : b_we;
			mem_addr <= a_pend ? a_addr.w.word : b_addr.w.word;
			mem_d    <= a_pend ? a_din : b_din;
			mem_ds   <= a_pend ? a_ds : b_ds;
		end
		if (done) begin
			if (grant_b)
				b_q <= mem_q;
			else
				a_q <= mem_q;
		end
	end

endmodule

`default_nettype wire

// File: src/word_ram.sv
`default_nettype none
`timescale 1ns/1ns

module word_ram #(
	parameter int WORD_BITS = zx_mem_pkg::WORD_BITS_DEF
) (
	input  wire         clk_sys,
	input  wire         en,
	input  wire         we,
	input  wire  [23:0] addr,
	input  wire  [15:0] d,
	input  wire  [1:0]  ds,
	output logic [15:0] q
);

	logic [15:0]          mem [0:(1 << WORD_BITS) - 1];
	logic [WORD_BITS-1:0] a;
	logic [15:0]          q_stage;  // First read stage

	assign a = addr[WORD_BITS-1:0];  // Upper bits not decoded

	always_ff @(posedge clk_sys) begin
		if (en) begin
			if (we && ds[0])
				mem[a][7:0] <= d[7:0];
			if (we && ds[1])
				mem[a][15:8] <= d[15:8];
			q_stage <= mem[a];
		end
		q <= q_stage;  // Valid two cycles after en
	end

endmodule

`default_nettype wire

// File: src/zx_memsys.sv
`default_nettype none
`timescale 1ns/1ns

module zx_memsys (
	input  wire         clk_sys,
	input  wire         reset,
	input  wire  [1:0]  model,
	input  wire  [1:0]  gs_size,
	input  wire  [15:0] cpu_addr,
	input  wire  [7:0]  cpu_dout,
	input  wire         cpu_mreq,
	input  wire         cpu_iorq,
	input  wire         cpu_rd,
	input  wire         cpu_wr,
	input  wire         dl_active,
	input  wire         dl_wr,
	input  wire  [24:0] dl_addr,
	input  wire  [7:0]  dl_data,
	input  wire  [20:0] gs_addr,
	input  wire  [7:0]  gs_din,
	input  wire         gs_rd,
	input  wire         gs_wr,
	output logic [7:0]  ram_dout,
	output logic        ram_ready,
	output logic [7:0]  gs_dout,
	output logic        gs_ready
);
	import zx_mem_pkg::*;

	// Paging to CPU port
	mem_addr_u   ram_addr;
	logic        ram_rd;
	logic        ram_we;
	logic [7:0]  ram_din;

	// CPU port to arbiter
	logic        cpu_req;
	mem_addr_u   cpu_req_addr;
	logic        cpu_req_we;
	logic [15:0] cpu_req_din;
	logic [1:0]  cpu_req_ds;
	logic        cpu_ack;
	logic [15:0] cpu_q;

	// GS port to arbiter
	logic        gs_req;
	mem_addr_u   gs_req_addr;
	logic        gs_req_we;
	logic [15:0] gs_req_din;
	logic [1:0]  gs_req_ds;
	logic        gs_ack;
	logic [15:0] gs_q;

	// Arbiter to word memory
	logic        mem_en;
	logic        mem_we;
	logic [23:0] mem_addr;
	logic [15:0] mem_d;
	logic [1:0]  mem_ds;
	logic [15:0] mem_q;

	zx_paging zx_paging_inst (
		.clk_sys(clk_sys), .reset(reset), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
		.cpu_mreq(cpu_mreq), .cpu_iorq(cpu_iorq), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
		.model(model), .ram_addr(ram_addr), .ram_rd(ram_rd), .ram_we(ram_we),
		.ram_din(ram_din)
	);

	cpu_mem_port cpu_mem_port_inst (
		.clk_sys(clk_sys), .reset(reset), .ram_addr(ram_addr), .ram_rd(ram_rd),
		.ram_we(ram_we), .ram_din(ram_din), .dl_active(dl_active), .dl_wr(dl_wr),
		.dl_addr(dl_addr), .dl_data(dl_data), .ack(cpu_ack), .q(cpu_q),
		.req(cpu_req), .addr(cpu_req_addr), .we(cpu_req_we), .din(cpu_req_din),
		.ds(cpu_req_ds), .ram_dout(ram_dout), .ram_ready(ram_ready)
	);

	gs_mem_port gs_mem_port_inst (
		.clk_sys(clk_sys), .reset(reset), .gs_addr(gs_addr), .gs_din(gs_din),
		.gs_rd(gs_rd), .gs_wr(gs_wr), .gs_size(gs_size), .ack(gs_ack), .q(gs_q),
		.req(gs_req), .addr(gs_req_addr), .we(gs_req_we), .din(gs_req_din),
		.ds(gs_req_ds), .gs_dout(gs_dout), .gs_ready(gs_ready)
	);

	// Port a is the CPU and wins ties
	mem_arbiter mem_arbiter_inst (
		.clk_sys(clk_sys), .reset(reset),
		.a_req(cpu_req), .a_addr(cpu_req_addr), .a_we(cpu_req_we), .a_din(cpu_req_din),
		.a_ds(cpu_req_ds), .a_ack(cpu_ack), .a_q(cpu_q),
		.b_req(gs_req), .b_addr(gs_req_addr), .b_we(gs_req_we), .b_din(gs_req_din),
		.b_ds(gs_req_ds), .b_ack(gs_ack), .b_q(gs_q),
		.mem_q(mem_q), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_d(mem_d), .mem_ds(mem_ds)
	);

	word_ram #(
		.WORD_BITS(WORD_BITS_DEF)
	) word_ram_inst (
		.clk_sys(clk_sys), .en(mem_en), .we(mem_we), .addr(mem_addr), .d(mem_d),
		.ds(mem_ds), .q(mem_q)
	);

endmodule

`default_nettype wire

// File: bench/zx_memsys_tb.sv
`default_nettype none
`timescale 1ns/1ns

module zx_memsys_tb;

	localparam int TIMEOUT = 100;  // Cycles allowed per ready wait
	localparam int PAR_MAX = 64;

	logic        clk_sys;
	logic        reset;
	logic [1:0]  model;
	logic [1:0]  gs_size;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        cpu_mreq;
	logic        cpu_iorq;
	logic        cpu_rd;
	logic        cpu_wr;
	logic        dl_active;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic [20:0] gs_addr;
	logic [7:0]  gs_din;
	logic        gs_rd;
	logic        gs_wr;
	wire  [7:0]  ram_dout;
	wire         ram_ready;
	wire  [7:0]  gs_dout;
	wire         gs_ready;

	int          errors;
	int          checks;
	int          timeouts;
	int          seed;
	logic [31:0] cpu_rnd [0:PAR_MAX-1];
	logic [31:0] gs_rnd [0:PAR_MAX-1];
	logic [7:0]  cpu_shadow [0:255];  // Bank 5 window at 4000
	logic [7:0]  gs_shadow [0:255];   // GS window at 01000

	zx_memsys zx_memsys_inst (
		.clk_sys(clk_sys), .reset(reset), .model(model), .gs_size(gs_size),
		.cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_mreq(cpu_mreq),
		.cpu_iorq(cpu_iorq), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.gs_addr(gs_addr), .gs_din(gs_din), .gs_rd(gs_rd), .gs_wr(gs_wr),
		.ram_dout(ram_dout), .ram_ready(ram_ready), .gs_dout(gs_dout),
		.gs_ready(gs_ready)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Checks and ready waits
	// ======================================================================

	task automatic check_byte(input string name, input logic [24:0] a,
			input logic [7:0] exp, input logic [7:0] got);
		checks++;
		assert (got === exp) else begin
			$display("Error: %s at %h expected %h got %h", name, a, exp, got);
			errors++;
		end
	endtask

	task automatic wait_ready(input logic gs_side);
		int n;
		n = 0;
		@(negedge clk_sys);  // Ready is low by now if an access was issued
		while (!(gs_side ? gs_ready : ram_ready) && n < TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!(gs_side ? gs_ready : ram_ready)) begin
			$display("Timeout: %s did not return within %0d cycles",
				gs_side ? "gs_ready" : "ram_ready", TIMEOUT);
			timeouts++;
		end
	endtask

	task automatic reset_dut(input logic [1:0] m, input logic [1:0] s);
		@(negedge clk_sys);
		model   = m;  // Latched by the paging unit during reset
		gs_size = s;
		reset   = 1'b1;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// ======================================================================
	// Bus operations, all driven on the falling edge
	// ======================================================================

	task automatic dl_write(input logic [24:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		dl_active = 1'b1;
		dl_addr   = a;
		dl_data   = d;
		dl_wr     = 1'b1;
		wait_ready(1'b0);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		cpu_addr = a;
		cpu_dout = d;
		cpu_mreq = 1'b1;
		cpu_wr   = 1'b1;
		wait_ready(1'b0);  // Returns at once for a protected ROM write
		cpu_mreq = 1'b0;
		cpu_wr   = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] a, input logic [7:0] exp);
		@(negedge clk_sys);
		cpu_addr = a;
		cpu_mreq = 1'b1;
		cpu_rd   = 1'b1;
		wait_ready(1'b0);
		check_byte("ram_dout", 25'(a), exp, ram_dout);
		cpu_mreq = 1'b0;
		cpu_rd   = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] port, input logic [7:0] d);
		@(negedge clk_sys);
		cpu_addr = port;
		cpu_dout = d;
		cpu_iorq = 1'b1;
		cpu_wr   = 1'b1;
		@(negedge clk_sys);  // Page register taken on the first rising edge
		cpu_iorq = 1'b0;
		cpu_wr   = 1'b0;
	endtask

	task automatic gs_write(input logic [20:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		gs_addr = a;
		gs_din  = d;
		gs_wr   = 1'b1;
		wait_ready(1'b1);
		gs_wr = 1'b0;
	endtask

	task automatic gs_read(input logic [20:0] a, input logic [7:0] exp);
		@(negedge clk_sys);
		gs_addr = a;
		gs_rd   = 1'b1;
		wait_ready(1'b1);
		check_byte("gs_dout", 25'(a), exp, gs_dout);
		gs_rd = 1'b0;
	endtask

	// ======================================================================
	// Random traffic on both ports at once
	// ======================================================================

	task automatic cpu_traffic(input int n);
		int         i;
		int         k;
		logic [7:0] a;
		for (i = 0; i < n; i++) begin
			a = cpu_rnd[i][7:0];
			cpu_write({8'h40, a}, cpu_rnd[i][15:8]);
			cpu_shadow[a] = cpu_rnd[i][15:8];
			k = int'(cpu_rnd[i][31:16]) % (i + 1);  // Some address written so far
			a = cpu_rnd[k][7:0];
			cpu_read({8'h40, a}, cpu_shadow[a]);
		end
	endtask

	task automatic gs_traffic(input int n);
		int         i;
		int         k;
		logic [7:0] a;
		for (i = 0; i < n; i++) begin
			a = gs_rnd[i][7:0];
			gs_write({13'h0010, a}, gs_rnd[i][15:8]);
			gs_shadow[a] = gs_rnd[i][15:8];
			k = int'(gs_rnd[i][31:16]) % (i + 1);
			a = gs_rnd[k][7:0];
			gs_read({13'h0010, a}, gs_shadow[a]);
		end
	endtask

	task automatic run_parallel(input int count);
		int i;
		int n;
		n = (count > PAR_MAX) ? PAR_MAX : count;
		for (i = 0; i < n; i++) begin
			cpu_rnd[i] = $random(seed);
			gs_rnd[i]  = $random(seed);
		end
		fork
			cpu_traffic(n);
			gs_traffic(n);
		join
	endtask

	task automatic run_op(input logic [15:0] op, input logic [31:0] f1,
			input logic [31:0] f2);
		case (op)
			"rs":    reset_dut(f1[1:0], f2[1:0]);
			"dl":    dl_write(f1[24:0], f2[7:0]);
			"mw":    cpu_write(f1[15:0], f2[7:0]);
			"mr":    cpu_read(f1[15:0], f2[7:0]);
			"io":    io_write(f1[15:0], f2[7:0]);
			"gw":    gs_write(f1[20:0], f2[7:0]);
			"gr":    gs_read(f1[20:0], f2[7:0]);
			"pr":    run_parallel(f1);
			default: begin
				$display("Unknown operation %s in the case file", op);
				errors++;
			end
		endcase
	endtask

	initial begin
		int                 fd;
		int                 r;
		logic [15:0]        op;
		logic [31:0]        f1;
		logic [31:0]        f2;
		logic [8*160-1:0]   line;
		reset     = 1'b1;
		model     = 2'd0;
		gs_size   = 2'd2;
		cpu_addr  = 16'h0000;
		cpu_dout  = 8'h00;
		cpu_mreq  = 1'b0;
		cpu_iorq  = 1'b0;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = 25'd0;
		dl_data   = 8'h00;
		gs_addr   = 21'd0;
		gs_din    = 8'h00;
		gs_rd     = 1'b0;
		gs_wr     = 1'b0;
		errors    = 0;
		checks    = 0;
		timeouts  = 0;
		seed      = 78;
		reset_dut(2'd0, 2'd2);

		fd = $fopen("bench/zx_memsys_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file bench/zx_memsys_cases.txt");
			errors++;
		end else begin
			r = $fscanf(fd, "%s", op);
			while (r == 1) begin
				if (op == "//") begin
					r = $fgets(line, fd);  // Skip the comment text
				end else begin
					r = $fscanf(fd, "%h %h", f1, f2);
					if (r != 2) begin
						$display("Malformed case line for operation %s", op);
						errors++;
					end else begin
						run_op(op, f1, f2);
					end
				end
				r = $fscanf(fd, "%s", op);
			end
			$fclose(fd);
		end

		$display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/zx_memsys_cases.txt
// op field1 field2, both fields hex; mr and gr compare the byte read with field2
// rs model gs_size | dl byte address | mw mr io CPU bus | gw gr GS bus | pr count 0
// 48K ROM slot 15 loaded by download, read only from the CPU
rs 1 2
dl 17C000 C3
dl 17C001 5F
dl 17FFFF 76
mr 0000 C3
mr 0001 5F
mr 3FFF 76
mw 0001 00
mr 0001 5F
io 7FFD 10
mr 0000 C3
// 128K bank switching at C000
rs 0 2
io 7FFD 03
mw C000 33
io 7FFD 05
mw C000 A5
mw C001 5A
mr 4000 A5
mr 4001 5A
io 7FFD 03
mr C000 33
// 128K ROM select and page lock
dl 158000 06
dl 15C000 07
io 7FFD 00
mr 0000 06
mw C000 B0
io 7FFD 10
mr 0000 07
io 7FFD 30
io 7FFD 03
mr 0000 07
mr C000 B0
// +3 ROM protection and all-RAM modes
rs 2 2
dl 160000 88
mr 0000 88
mw 0000 11
mr 0000 88
io 7FFD 04
mw C000 44
io 7FFD 00
io 1FFD 01
mw 0000 E0
mr 0000 E0
mr C000 33
io 1FFD 07
mr 0000 44
mr C000 33
rs 2 2
mr 0000 88
// GS bytes in both lanes, reused word and size mask
rs 0 2
gw 000000 11
gw 000001 22
gr 000000 11
gr 000001 22
gw 080010 5A
gr 080010 5A
rs 0 0
gr 080010 FF
gr 000001 22
rs 0 1
gr 080010 5A
gr 100000 FF
// CPU and GS traffic at once
rs 0 2
pr 40 0

// File: zx_memsys.f
src/zx_mem_pkg.sv
src/zx_io_pkg.sv
src/zx_paging.sv
src/cpu_mem_port.sv
src/gs_mem_port.sv
src/mem_arbiter.sv
src/word_ram.sv
src/zx_memsys.sv
bench/zx_memsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the zx_memsys testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module zx_memsys_tb -f zx_memsys.f --Mdir "$OBJ" -o zx_memsys_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/zx_memsys_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	exit 1
fi
exit 0
